// ==== files.f ====
common/rlbp_pkg.sv
timing/pulse_channel.sv
timing/timing_gen.sv
rlbp/rlbp_capture.sv
rlbp/rlbp_serializer.sv
logic/wb_config_regs.sv
logic/sensor_readout_top.sv
verif/tb_sensor_readout.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sensor_readout
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_sensor_readout.sv ====
// Testbench for the sensor readout controller
// Wishbone master tasks, random comparator stimulus, reference window and checks
`timescale 1ns/10ps

module tb_sensor_readout;

	localparam int NCH            = 7;
	localparam int FRAME_LEN      = 40;
	localparam int ACK_LIMIT      = 8;
	localparam int TIMEOUT_CYCLES = 12 * FRAME_LEN + 2000;
	localparam int RISE_TAB [NCH] = '{1, 3, 6, 10, 15, 22, 30};
	localparam int FALL_TAB [NCH] = '{5, 9, 14, 20, 25, 26, 12};

	logic        clk;
	logic        reset;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [7:0]  wb_adr_i;
	logic [31:0] wb_dat_i;
	logic        cmp_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic [NCH-1:0] pulse_o;
	logic        ser_data_o;
	logic        ser_valid_o;

	integer      seed = 83;
	integer      rnd;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic        samples [rlbp_pkg::WINDOW_BITS];
	int          nsamp = 0;
	logic        sh_prev = 1'b0;
	logic [8:0]  ser_word = '0;
	int          ser_len = 0;
	int          ser_done = 0;
	int          high_cnt [NCH];
	int          first_hi [NCH];
	logic [31:0] rd;
	rlbp_pkg::reg_word_u edge_word;

	sensor_readout_top #(.NUM_CHANNELS(NCH)) sensor_readout_top_i (
		.clk (clk), .reset (reset),
		.wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
		.wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .cmp_i (cmp_i),
		.wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .pulse_o (pulse_o),
		.ser_data_o (ser_data_o), .ser_valid_o (ser_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Samples in arrival order fill the window from bit 0 upward
	function automatic logic [8:0] expected_window(input logic s [rlbp_pkg::WINDOW_BITS]);
		logic [8:0] w;
		w = '0;
		for (int k = 0; k < rlbp_pkg::WINDOW_BITS; k++)
			w[k] = s[k];
		return w;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
		end
	endtask

	task automatic wait_for_ack(input logic [7:0] adr);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack_o && waited < ACK_LIMIT);
		if (!wb_ack_o) begin
			errors++;
			$display("No Wishbone acknowledge for address 0x%0h within %0d cycles", adr,
				ACK_LIMIT);
		end
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
		@(negedge clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b1;
		wb_adr_i = adr;
		wb_dat_i = dat;
		wait_for_ack(adr);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
		@(negedge clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = adr;
		wait_for_ack(adr);
		dat      = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
	endtask

	// Random comparator bits, recording the one held at each sh_cmp rise
	always @(negedge clk) begin
		if (pulse_o[rlbp_pkg::SH_CMP_CH] && !sh_prev && nsamp < rlbp_pkg::WINDOW_BITS) begin
			samples[nsamp] = cmp_i;
			nsamp++;
		end
		sh_prev = pulse_o[rlbp_pkg::SH_CMP_CH];
		rnd     = $random(seed);
		cmp_i   = rnd[0];
	end

	// Serial output checker
	always @(negedge clk) begin
		if (ser_valid_o) begin
			if (ser_len < rlbp_pkg::WINDOW_BITS)
				ser_word[ser_len] = ser_data_o;
			ser_len++;
		end else if (ser_len != 0) begin
			check_value(ser_len, rlbp_pkg::WINDOW_BITS, "serial valid length");
			check_value(32'(ser_word), 32'(expected_window(samples)), "serialized window");
			ser_len  = 0;
			ser_word = '0;
			ser_done++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not complete", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		reset    = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		cmp_i    = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Idle outputs before any configuration
		repeat (10) begin
			@(negedge clk);
			check_value(32'(pulse_o), 0, "pulses after reset");
			check_value(32'(ser_valid_o), 0, "ser_valid_o after reset");
			check_value(32'(wb_ack_o), 0, "wb_ack_o while idle");
		end
		wb_read(rlbp_pkg::REG_STATUS, rd);
		check_value(rd, 0, "status after reset");
		wb_read(8'h0C, rd);
		check_value(rd, 0, "unmapped offset");

		wb_write(rlbp_pkg::REG_FRAME, FRAME_LEN);
		wb_read(rlbp_pkg::REG_FRAME, rd);
		check_value(rd, FRAME_LEN, "frame length readback");
		for (int ch = 0; ch < NCH; ch++) begin
			edge_word            = '0;
			edge_word.edges.rise = 12'(RISE_TAB[ch]);
			edge_word.edges.fall = 12'(FALL_TAB[ch]);
			wb_write(rlbp_pkg::REG_EDGE_BASE + 8'(4 * ch), edge_word);
			wb_read(rlbp_pkg::REG_EDGE_BASE + 8'(4 * ch), rd);
			check_value(rd, {4'b0, 12'(FALL_TAB[ch]), 4'b0, 12'(RISE_TAB[ch])},
				$sformatf("channel %0d edge readback", ch));
		end

		// Strobe windows over the first two frames of the first capture
		nsamp = 0;
		wb_write(rlbp_pkg::REG_CTRL, 32'h1);
		for (int ch = 0; ch < NCH; ch++) begin
			high_cnt[ch] = 0;
			first_hi[ch] = 0;
		end
		for (int k = 1; k <= 2 * FRAME_LEN; k++) begin
			@(negedge clk);
			for (int ch = 0; ch < NCH; ch++) begin
				if (pulse_o[ch]) begin
					high_cnt[ch]++;
					if (first_hi[ch] == 0)
						first_hi[ch] = k;
				end
			end
		end
		for (int ch = 0; ch < NCH; ch++) begin
			check_value(high_cnt[ch], FALL_TAB[ch] > RISE_TAB[ch] ?
				2 * (FALL_TAB[ch] - RISE_TAB[ch]) : 0,
				$sformatf("channel %0d high cycles", ch));
			check_value(first_hi[ch], FALL_TAB[ch] > RISE_TAB[ch] ? RISE_TAB[ch] + 1 : 0,
				$sformatf("channel %0d first high cycle", ch));
		end

		for (int run = 1; run <= 2; run++) begin
			if (run == 2) begin
				nsamp = 0;
				wb_write(rlbp_pkg::REG_CTRL, 32'h1);
			end
			while (ser_done < run)
				@(negedge clk);
			wb_read(rlbp_pkg::REG_STATUS, rd);
			check_value(rd, {22'b0, expected_window(samples), 1'b1}, "status after capture");
			wb_write(rlbp_pkg::REG_CTRL, 32'h0);
			wb_read(rlbp_pkg::REG_STATUS, rd);
			check_value(32'(rd[0]), 0, "done after stop");
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== logic/sensor_readout_top.sv ====
// Pixel readout controller top level
// Config registers, strobe timing, RLBP capture and serializer
`timescale 1ns/10ps

module sensor_readout_top #(
	parameter int NUM_CHANNELS = 7
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           wb_cyc_i,
	input  logic                           wb_stb_i,
	input  logic                           wb_we_i,
	input  logic [rlbp_pkg::WB_ADDR_W-1:0] wb_adr_i,
	input  logic [rlbp_pkg::WB_DATA_W-1:0] wb_dat_i,
	input  logic                           cmp_i,
	output logic [rlbp_pkg::WB_DATA_W-1:0] wb_dat_o,
	output logic                           wb_ack_o,
	output logic [NUM_CHANNELS-1:0]        pulse_o,
	output logic                           ser_data_o,
	output logic                           ser_valid_o
);

	logic [NUM_CHANNELS*rlbp_pkg::COUNT_W-1:0] rise;
	logic [NUM_CHANNELS*rlbp_pkg::COUNT_W-1:0] fall;
	logic [rlbp_pkg::COUNT_W-1:0]              frame_len;
	logic                                      start;
	logic                                      done;
	logic                                      load;
	logic [rlbp_pkg::WINDOW_BITS-1:0]          window;
	logic                                      cmp_q;

	// Comparator bit from the pixel array
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			cmp_q <= 1'b0;
		else
			cmp_q <= cmp_i;
	end

	wb_config_regs #(.NUM_CHANNELS(NUM_CHANNELS)) wb_config_regs_i (
		.clk (clk), .reset (reset),
		.wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
		.wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
		.rise_o (rise), .fall_o (fall), .frame_len_o (frame_len), .start_o (start),
		.done_i (done), .window_i (window)
	);

	timing_gen #(.NUM_CHANNELS(NUM_CHANNELS)) timing_gen_i (
		.clk (clk), .reset (reset), .start_i (start), .frame_len_i (frame_len),
		.rise_i (rise), .fall_i (fall), .pulse_o (pulse_o)
	);

	rlbp_capture rlbp_capture_i (
		.clk (clk), .reset (reset), .start_i (start),
		.pxl_done_i (pulse_o[rlbp_pkg::SH_CMP_CH]), .cmp_i (cmp_q),
		.done_o (done), .load_o (load), .window_o (window)
	);

	rlbp_serializer rlbp_serializer_i (
		.clk (clk), .reset (reset), .load_i (load), .window_i (window),
		.ser_data_o (ser_data_o), .ser_valid_o (ser_valid_o)
	);

endmodule

// ==== logic/wb_config_regs.sv ====
// Wishbone classic slave for the readout configuration
// Control, frame length, per-channel edges and capture status
`timescale 1ns/10ps

module wb_config_regs #(
	parameter int NUM_CHANNELS = 7
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          wb_cyc_i,
	input  logic                                          wb_stb_i,
	input  logic                                          wb_we_i,
	input  logic [rlbp_pkg::WB_ADDR_W-1:0]                wb_adr_i,
	input  logic [rlbp_pkg::WB_DATA_W-1:0]                wb_dat_i,
	output logic [rlbp_pkg::WB_DATA_W-1:0]                wb_dat_o,
	output logic                                          wb_ack_o,
	output logic [NUM_CHANNELS*rlbp_pkg::COUNT_W-1:0]     rise_o,
	output logic [NUM_CHANNELS*rlbp_pkg::COUNT_W-1:0]     fall_o,
	output logic [rlbp_pkg::COUNT_W-1:0]                  frame_len_o,
	output logic                                          start_o,
	input  logic                                          done_i,
	input  logic [rlbp_pkg::WINDOW_BITS-1:0]              window_i
);

	localparam int EIDX_W = rlbp_pkg::WB_ADDR_W - 2;

	logic [rlbp_pkg::COUNT_W-1:0] rise_q [NUM_CHANNELS];
	logic [rlbp_pkg::COUNT_W-1:0] fall_q [NUM_CHANNELS];
	logic [rlbp_pkg::COUNT_W-1:0] frame_len_q;
	logic                         start_q;
	logic                         req;
	logic [rlbp_pkg::WB_ADDR_W-1:0] edge_off;
	logic [EIDX_W-1:0]              edge_idx;
	logic                           edge_hit;
	rlbp_pkg::reg_word_u            wr_word;
	rlbp_pkg::reg_word_u            rd_word;

	// New request only while no ack is out, so ack lasts one cycle
	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

	assign edge_off = wb_adr_i - rlbp_pkg::REG_EDGE_BASE;
	assign edge_idx = edge_off[rlbp_pkg::WB_ADDR_W-1:2];
	assign edge_hit = (wb_adr_i >= rlbp_pkg::REG_EDGE_BASE) && (wb_adr_i[1:0] == 2'b00);
	assign wr_word  = wb_dat_i;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb_ack_o    <= 1'b0;
			start_q     <= 1'b0;
			frame_len_q <= '0;
			for (int n = 0; n < NUM_CHANNELS; n++) begin
				rise_q[n] <= '0;
				fall_q[n] <= '0;
			end
		end else begin
			wb_ack_o <= req;
			if (req && wb_we_i) begin
				if (wb_adr_i == rlbp_pkg::REG_CTRL)
					start_q <= wr_word.ctrl.flag;
				if (wb_adr_i == rlbp_pkg::REG_FRAME)
					frame_len_q <= wb_dat_i[rlbp_pkg::COUNT_W-1:0];
				for (int n = 0; n < NUM_CHANNELS; n++) begin
					if (edge_hit && edge_idx == EIDX_W'(n)) begin
						rise_q[n] <= wr_word.edges.rise;
						fall_q[n] <= wr_word.edges.fall;
					end
				end
			end
		end
	end

	// Read mux, unmapped offsets give zero
	always_comb begin
		rd_word = '0;
		if (wb_adr_i == rlbp_pkg::REG_CTRL) begin
			rd_word.ctrl.flag = start_q;
		end else if (wb_adr_i == rlbp_pkg::REG_FRAME) begin
			rd_word = rlbp_pkg::WB_DATA_W'(frame_len_q);
		end else if (wb_adr_i == rlbp_pkg::REG_STATUS) begin
			// Live capture status
			rd_word.ctrl.flag   = done_i;
			rd_word.ctrl.window = window_i;
		end else begin
			for (int n = 0; n < NUM_CHANNELS; n++) begin
				if (edge_hit && edge_idx == EIDX_W'(n)) begin
					rd_word.edges.rise = rise_q[n];
					rd_word.edges.fall = fall_q[n];
				end
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			wb_dat_o <= '0;
		else if (req && !wb_we_i)
			wb_dat_o <= rd_word;
	end

	for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_flat
		assign rise_o[n*rlbp_pkg::COUNT_W +: rlbp_pkg::COUNT_W] = rise_q[n];
		assign fall_o[n*rlbp_pkg::COUNT_W +: rlbp_pkg::COUNT_W] = fall_q[n];
	end

	assign frame_len_o = frame_len_q;
	assign start_o     = start_q;

endmodule

// ==== rlbp/rlbp_serializer.sv ====
// Window serializer, LSB first with a valid flag
`timescale 1ns/10ps

module rlbp_serializer (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             load_i,
	input  logic [rlbp_pkg::WINDOW_BITS-1:0] window_i,
	output logic                             ser_data_o,
	output logic                             ser_valid_o
);

	localparam int CNT_W = $clog2(rlbp_pkg::WINDOW_BITS);

	logic [rlbp_pkg::WINDOW_BITS-1:0] shift_q;
	logic [CNT_W-1:0]                 bits_left;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shift_q     <= '0;
			bits_left   <= '0;
			ser_data_o  <= 1'b0;
			ser_valid_o <= 1'b0;
		end else if (!ser_valid_o) begin
			if (load_i) begin
				// Bit 0 goes out straight away
				ser_data_o  <= window_i[0];
				ser_valid_o <= 1'b1;
				shift_q     <= {1'b0, window_i[rlbp_pkg::WINDOW_BITS-1:1]};
				bits_left   <= CNT_W'(rlbp_pkg::WINDOW_BITS - 1);
			end
		end else if (bits_left != '0) begin
			ser_data_o <= shift_q[0];
			shift_q    <= {1'b0, shift_q[rlbp_pkg::WINDOW_BITS-1:1]};
			bits_left  <= bits_left - 1'b1;
		end else begin
			ser_data_o  <= 1'b0;
			ser_valid_o <= 1'b0;
		end
	end

endmodule

// ==== rlbp/rlbp_capture.sv ====
// RLBP capture sequencer
// Samples the comparator on sh_cmp rising edges into a 3x3 window
`timescale 1ns/10ps

module rlbp_capture (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start_i,
	input  logic                             pxl_done_i,
	input  logic                             cmp_i,
	output logic                             done_o,
	output logic                             load_o,
	output logic [rlbp_pkg::WINDOW_BITS-1:0] window_o
);

	localparam int ROWS  = rlbp_pkg::WINDOW_BITS / rlbp_pkg::ROW_LEN;
	localparam int RW    = $clog2(ROWS);
	localparam int CW    = $clog2(rlbp_pkg::ROW_LEN);
	localparam int IDX_W = $clog2(rlbp_pkg::WINDOW_BITS);

	localparam logic [RW-1:0] LAST_ROW = RW'(ROWS - 1);
	localparam logic [CW-1:0] LAST_COL = CW'(rlbp_pkg::ROW_LEN - 1);

	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_COLLECT = 2'd1;
	localparam logic [1:0] ST_HOLD    = 2'd2;

	logic [1:0]       state;
	logic             pxl_d;
	logic             pxl_rise;
	logic [RW-1:0]    row_cnt;
	logic [CW-1:0]    col_cnt;
	logic [IDX_W-1:0] bit_idx;
	logic             last_sample;

	assign pxl_rise    = pxl_done_i && !pxl_d;
	assign bit_idx     = IDX_W'(row_cnt * rlbp_pkg::ROW_LEN + col_cnt);
	assign last_sample = (row_cnt == LAST_ROW) && (col_cnt == LAST_COL);

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pxl_d <= 1'b0;
		else
			pxl_d <= pxl_done_i;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= ST_IDLE;
			row_cnt  <= '0;
			col_cnt  <= '0;
			done_o   <= 1'b0;
			load_o   <= 1'b0;
			window_o <= '0;
		end else begin
			load_o <= 1'b0;
			if (!start_i) begin
				// Stop aborts or ends the capture
				state   <= ST_IDLE;
				row_cnt <= '0;
				col_cnt <= '0;
				done_o  <= 1'b0;
			end else begin
				case (state)
					ST_IDLE:
						state <= ST_COLLECT;
					ST_COLLECT:
						if (pxl_rise) begin
							window_o[bit_idx] <= cmp_i;
							if (last_sample) begin
								state  <= ST_HOLD;
								done_o <= 1'b1;
								load_o <= 1'b1;
							end else if (col_cnt == LAST_COL) begin
								// Next row of the neighbourhood
								col_cnt <= '0;
								row_cnt <= row_cnt + 1'b1;
							end else begin
								col_cnt <= col_cnt + 1'b1;
							end
						end
					// Wait here for start to drop
					default:
						state <= ST_HOLD;
				endcase
			end
		end
	end

endmodule

// ==== timing/timing_gen.sv ====
// Frame counter with programmable wrap
// Bank of pulse channels driven from the shared count
`timescale 1ns/10ps

module timing_gen #(
	parameter int NUM_CHANNELS = 7
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      start_i,
	input  logic [rlbp_pkg::COUNT_W-1:0]              frame_len_i,
	input  logic [NUM_CHANNELS*rlbp_pkg::COUNT_W-1:0] rise_i,
	input  logic [NUM_CHANNELS*rlbp_pkg::COUNT_W-1:0] fall_i,
	output logic [NUM_CHANNELS-1:0]                   pulse_o
);

	logic [rlbp_pkg::COUNT_W-1:0] count_q;
	logic [rlbp_pkg::COUNT_W-1:0] last_count;

	assign last_count = frame_len_i - rlbp_pkg::COUNT_W'(1);

	// Held at zero while stopped
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			count_q <= '0;
		else if (!start_i)
			count_q <= '0;
		else if (count_q >= last_count)
			count_q <= '0;
		else
			count_q <= count_q + 1'b1;
	end

	for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_chan
		pulse_channel pulse_channel_i (
			.clk     (clk),
			.reset   (reset),
			.count_i (count_q),
			.rise_i  (rise_i[n*rlbp_pkg::COUNT_W +: rlbp_pkg::COUNT_W]),
			.fall_i  (fall_i[n*rlbp_pkg::COUNT_W +: rlbp_pkg::COUNT_W]),
			.pulse_o (pulse_o[n])
		);
	end

endmodule

// ==== timing/pulse_channel.sv ====
// Single programmable strobe, high between rise and fall counts
`timescale 1ns/10ps

module pulse_channel (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [rlbp_pkg::COUNT_W-1:0] count_i,
	input  logic [rlbp_pkg::COUNT_W-1:0] rise_i,
	input  logic [rlbp_pkg::COUNT_W-1:0] fall_i,
	output logic                         pulse_o
);

	logic in_window;

	// Empty window when rise is not below fall
	assign in_window = (count_i >= rise_i) && (count_i < fall_i);

	// Strobe lags the count by one cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pulse_o <= 1'b0;
		else
			pulse_o <= in_window;
	end

endmodule

// ==== common/rlbp_pkg.sv ====
// Shared widths, Wishbone register map and sh_cmp channel index
// Register word union with edge-pair and control/status views
package rlbp_pkg;

	localparam int COUNT_W     = 12;
	localparam int WB_DATA_W   = 32;
	localparam int WB_ADDR_W   = 8;
	localparam int WINDOW_BITS = 9;
	localparam int ROW_LEN     = 3;
	localparam int SH_CMP_CH   = 5;

	// Byte offsets
	localparam logic [WB_ADDR_W-1:0] REG_CTRL      = 8'h00;
	localparam logic [WB_ADDR_W-1:0] REG_FRAME     = 8'h04;
	localparam logic [WB_ADDR_W-1:0] REG_STATUS    = 8'h08;
	localparam logic [WB_ADDR_W-1:0] REG_EDGE_BASE = 8'h10;

	// One data word, read as an edge pair or as control/status
	typedef union packed {
		struct packed {
			logic [WB_DATA_W-16-COUNT_W-1:0] rsv_hi;
			logic [COUNT_W-1:0]              fall;
			logic [16-COUNT_W-1:0]           rsv_lo;
			logic [COUNT_W-1:0]              rise;
		} edges;
		struct packed {
			logic [WB_DATA_W-WINDOW_BITS-2:0] rsv;
			logic [WINDOW_BITS-1:0]           window;
			logic                             flag;
		} ctrl;
	} reg_word_u;

endpackage
